//--- hdl/accum_pkg.sv
package accum_pkg;

	// Binary16 field widths
	localparam int HalfWidth = 16;
	localparam int ExpWidth = 5;
	localparam int MantWidth = 10;
	localparam int SigWidth = 15;   // Carry, hidden, fraction, guard, round, sticky

	localparam int ExpBias = 15;
	localparam int ExpMax = 31;     // All-ones exponent, infinity
	localparam int NumTerms = 8;    // Terms summed per run
	localparam int AddrWidth = 3;

	typedef logic [HalfWidth-1:0] half_t;
	typedef logic [ExpWidth-1:0] expo_t;
	typedef logic [MantWidth-1:0] mant_t;
	typedef logic [SigWidth-1:0] sig_t;
	typedef logic [AddrWidth-1:0] addr_t;

	// Adder input, one pair per valid cycle
	typedef struct packed {
		logic valid;
		half_t a;
		half_t b;
	} opPair_t;

	typedef struct packed {
		logic valid;
		logic effSub;        // Signs differ
		logic sign;          // Sign of larger operand
		expo_t exp;          // Common exponent
		sig_t bigSig;
		sig_t smallSig;      // Already aligned, sticky folded into bit 0
		logic bothZero;
	} alignStage_t;

	typedef struct packed {
		logic valid;
		logic sign;
		expo_t exp;
		sig_t raw;           // Unnormalized sum
		logic zero;
	} sumStage_t;

	typedef struct packed {
		logic valid;
		logic sign;
		logic [ExpWidth:0] exp;   // Two's complement, may dip below zero
		sig_t sig;                // Hidden bit at SigWidth-2
		logic zero;
	} normStage_t;

	typedef struct packed {
		logic valid;
		half_t value;
	} result_t;

	typedef enum logic [1:0] {
		Idle,
		Issue,
		Load,
		Wait
	} ctrlState_t;

endpackage

//--- hdl/fpAddAlign.sv
`timescale 1ns/1ps

module fpAddAlign (
	input logic ap_clk,
	input logic ap_rst,
	input accum_pkg::opPair_t operand,
	output accum_pkg::alignStage_t stage
);
	import accum_pkg::*;

	logic signA, signB;
	expo_t expA, expB;
	mant_t mantA, mantB;
	logic aZero, bZero;
	logic [HalfWidth-2:0] magA, magB;   // Exponent and fraction, zero when denormal
	logic aBig;
	sig_t sigA, sigB;
	expo_t expBig, expSmall, expDiff;
	sig_t sigSmall, shifted;
	logic sticky;
	alignStage_t next;

	// Field split
	always_comb begin
		signA = operand.a[HalfWidth-1];
		signB = operand.b[HalfWidth-1];
		expA = operand.a[MantWidth +: ExpWidth];
		expB = operand.b[MantWidth +: ExpWidth];
		mantA = operand.a[MantWidth-1:0];
		mantB = operand.b[MantWidth-1:0];
		aZero = expA == '0;   // Subnormals count as zero
		bZero = expB == '0;
	end

	always_comb begin
		magA = aZero ? '0 : operand.a[HalfWidth-2:0];
		magB = bZero ? '0 : operand.b[HalfWidth-2:0];
		aBig = magA >= magB;   // Ties go to A
		// Carry bit clear, hidden bit set, GRS empty
		sigA = aZero ? '0 : {2'b01, mantA, 3'b000};
		sigB = bZero ? '0 : {2'b01, mantB, 3'b000};
		expBig = aBig ? expA : expB;
		expSmall = aBig ? expB : expA;
		sigSmall = aBig ? sigB : sigA;
		expDiff = expBig - expSmall;
		shifted = sigSmall >> expDiff;
		// Any bit lost off the bottom goes into sticky
		sticky = (shifted << expDiff) != sigSmall;
	end

	always_comb begin
		next.valid = operand.valid;
		next.effSub = signA ^ signB;
		next.bothZero = aZero & bZero;
		// Two zeros add to -0 only when both are negative
		next.sign = next.bothZero ? (signA & signB) : (aBig ? signA : signB);
		next.exp = expBig;
		next.bigSig = aBig ? sigA : sigB;
		next.smallSig = {shifted[SigWidth-1:1], shifted[0] | sticky};
	end

	always_ff @(posedge ap_clk) begin
		stage <= next;
		if (ap_rst) begin
			stage.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/fpAddExecute.sv
`timescale 1ns/1ps

module fpAddExecute (
	input logic ap_clk,
	input logic ap_rst,
	input accum_pkg::alignStage_t stage,
	output accum_pkg::sumStage_t sum
);
	import accum_pkg::*;

	sig_t raw;
	logic exactZero;
	sumStage_t next;

	// Larger minus smaller never goes negative
	always_comb begin
		if (stage.effSub) begin
			raw = stage.bigSig - stage.smallSig;
		end else begin
			raw = stage.bigSig + stage.smallSig;   // Carry lands in the top bit
		end
		exactZero = raw == '0;
	end

	always_comb begin
		next.valid = stage.valid;
		next.exp = stage.exp;
		next.raw = raw;
		next.zero = exactZero;
		// Cancellation gives +0, a sum of two zeros keeps its own sign
		if (exactZero) begin
			next.sign = stage.bothZero & stage.sign;
		end else begin
			next.sign = stage.sign;
		end
	end

	always_ff @(posedge ap_clk) begin
		sum <= next;
		if (ap_rst) begin
			sum.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/fpAddNormalize.sv
`timescale 1ns/1ps

module fpAddNormalize (
	input logic ap_clk,
	input logic ap_rst,
	input accum_pkg::sumStage_t sum,
	output accum_pkg::normStage_t norm
);
	import accum_pkg::*;

	logic [3:0] lead;            // Left shift to bring leading one to hidden bit
	logic found;
	logic [ExpWidth:0] expIn;
	logic carry;
	normStage_t next;

	// Leading one search below the carry bit
	always_comb begin
		lead = '0;
		found = 1'b0;
		for (int i = SigWidth - 2; i >= 0; i--) begin
			if (!found && sum.raw[i]) begin
				lead = 4'(SigWidth - 2 - i);
				found = 1'b1;
			end
		end
	end

	always_comb begin
		expIn = {1'b0, sum.exp};
		carry = sum.raw[SigWidth-1];
		next.valid = sum.valid;
		next.sign = sum.sign;
		next.zero = sum.zero;
		if (carry) begin
			// Right by one, last two bits merge into sticky
			next.sig = {1'b0, sum.raw[SigWidth-1:2], sum.raw[1] | sum.raw[0]};
			if (sum.exp == expo_t'(ExpMax)) begin
				next.exp = expIn;   // Already infinite, hold so the field cannot wrap
			end else begin
				next.exp = expIn + 1'b1;
			end
		end else begin
			next.sig = sum.raw << lead;
			next.exp = expIn - {2'b00, lead};   // Can go negative
		end
	end

	always_ff @(posedge ap_clk) begin
		norm <= next;
		if (ap_rst) begin
			norm.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/fpAddRound.sv
`timescale 1ns/1ps

module fpAddRound (
	input logic ap_clk,
	input logic ap_rst,
	input accum_pkg::normStage_t norm,
	output accum_pkg::result_t result
);
	import accum_pkg::*;

	logic guardBit, roundBit, stickyBit;
	logic roundUp;
	logic [MantWidth+1:0] rounded;   // Hidden bit, fraction and one carry
	logic roundCarry;
	mant_t mant;
	logic signed [ExpWidth+1:0] expRnd;
	result_t next;

	// Nearest even
	always_comb begin
		guardBit = norm.sig[2];
		roundBit = norm.sig[1];
		stickyBit = norm.sig[0];
		roundUp = guardBit & (roundBit | stickyBit | norm.sig[3]);
		rounded = {1'b0, norm.sig[SigWidth-2:3]} + {{(MantWidth+1){1'b0}}, roundUp};
		roundCarry = rounded[MantWidth+1];
		mant = roundCarry ? rounded[MantWidth:1] : rounded[MantWidth-1:0];
		expRnd = $signed({norm.exp[ExpWidth], norm.exp})
			+ $signed({{(ExpWidth+1){1'b0}}, roundCarry});
	end

	always_comb begin
		next.valid = norm.valid;
		if (norm.zero) begin
			next.value = {norm.sign, {(HalfWidth-1){1'b0}}};
		end else if (expRnd >= ExpMax) begin
			next.value = {norm.sign, expo_t'(ExpMax), mant_t'(0)};   // Infinity
		end else if (expRnd <= 0) begin
			next.value = {norm.sign, {(HalfWidth-1){1'b0}}};   // Flush, sign kept
		end else begin
			next.value = {norm.sign, expRnd[ExpWidth-1:0], mant};
		end
	end

	always_ff @(posedge ap_clk) begin
		result <= next;
		if (ap_rst) begin
			result.valid <= 1'b0;
		end
	end

endmodule

//--- hdl/accumCtrl.sv
`timescale 1ns/1ps

module accumCtrl (
	input logic ap_clk,
	input logic ap_rst,
	input logic start,
	input logic cont,
	output logic done,
	output logic idle,
	output logic ready,
	output logic accumValid,
	output accum_pkg::half_t accumSum,
	output accum_pkg::addr_t memAddr,
	output logic memCe,
	input accum_pkg::half_t memData,
	output accum_pkg::opPair_t operand,
	input accum_pkg::result_t result
);
	import accum_pkg::*;

	ctrlState_t state, nextState;
	logic [AddrWidth:0] termIdx;   // One extra bit to reach NumTerms
	logic doneHeld;
	half_t sum;        // Running sum
	half_t lastSum;    // Shown between runs
	logic runStart;
	logic finish;

	assign runStart = (state == Idle) && start && !doneHeld;
	assign finish = (state == Issue) && (termIdx == (AddrWidth+1)'(NumTerms));

	always_comb begin
		nextState = state;
		case (state)
			Idle: begin
				if (runStart) begin
					nextState = Issue;
				end
			end
			Issue: nextState = finish ? Idle : Load;
			Load: nextState = Wait;     // Pair goes to the adder this cycle
			Wait: begin
				if (result.valid) begin
					nextState = Issue;
				end
			end
			default: nextState = Idle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= Idle;
		end else begin
			state <= nextState;
		end
	end

	// Index and running sum, cleared at the start of every run
	always_ff @(posedge ap_clk) begin
		if (ap_rst || runStart) begin
			termIdx <= '0;
			sum <= '0;
		end else if (state == Wait && result.valid) begin
			termIdx <= termIdx + 1'b1;
			sum <= result.value;
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			lastSum <= '0;
		end else if (finish) begin
			lastSum <= sum;
		end
	end

	// cont wins over a finish in the same cycle
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			doneHeld <= 1'b0;
		end else if (cont) begin
			doneHeld <= 1'b0;
		end else if (finish) begin
			doneHeld <= 1'b1;
		end
	end

	// Strobes
	always_comb begin
		done = finish | doneHeld;
		ready = finish;
		accumValid = finish;
		idle = (state == Idle) && !start;
		accumSum = finish ? sum : lastSum;
		memCe = (state == Issue) && !finish;
		memAddr = termIdx[AddrWidth-1:0];
	end

	// Read data arrives in Load, one cycle after memCe
	always_comb begin
		operand.valid = state == Load;
		operand.a = sum;
		operand.b = memData;
	end

endmodule

//--- hdl/halfAccum.sv
`timescale 1ns/1ps

module halfAccum (
	input logic ap_clk,
	input logic ap_rst,
	input logic start,
	input logic cont,
	output logic done,
	output logic idle,
	output logic ready,
	output logic accumValid,
	output accum_pkg::half_t accumSum,
	output accum_pkg::addr_t memAddr,
	output logic memCe,
	input accum_pkg::half_t memData
);
	import accum_pkg::*;

	opPair_t operand;
	alignStage_t aligned;
	sumStage_t added;
	normStage_t normed;
	result_t result;     // Valid four cycles after operand

	accumCtrl ctrl (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.start(start),
		.cont(cont),
		.done(done),
		.idle(idle),
		.ready(ready),
		.accumValid(accumValid),
		.accumSum(accumSum),
		.memAddr(memAddr),
		.memCe(memCe),
		.memData(memData),
		.operand(operand),
		.result(result)
	);

	fpAddAlign alignStage (.ap_clk(ap_clk), .ap_rst(ap_rst), .operand(operand), .stage(aligned));

	fpAddExecute execStage (.ap_clk(ap_clk), .ap_rst(ap_rst), .stage(aligned), .sum(added));

	fpAddNormalize normStage (.ap_clk(ap_clk), .ap_rst(ap_rst), .sum(added), .norm(normed));

	fpAddRound roundStage (.ap_clk(ap_clk), .ap_rst(ap_rst), .norm(normed), .result(result));

endmodule

//--- verification/fp16Model.svh
`ifndef FP16_MODEL_SVH
`define FP16_MODEL_SVH

// Binary16 add with the accumulator's rules, integer significands
function automatic half_t fp16Add(input half_t a, input half_t b);
	half_t x;
	half_t y;
	int unsigned mx, my, myFull, mr, keep, rem, halfWay;
	int ex, ey, er, lead, sh;
	if (a[14:10] == 5'h1f) begin
		return {a[15], 5'h1f, 10'h000};   // Infinity absorbs the term
	end
	if (b[14:10] == 5'h1f) begin
		return {b[15], 5'h1f, 10'h000};
	end
	if (a[14:10] == 5'h00 && b[14:10] == 5'h00) begin
		return {a[15] & b[15], 15'h0000};   // Negative only if both are
	end
	if (a[14:10] == 5'h00) begin
		return b;
	end
	if (b[14:10] == 5'h00) begin
		return a;
	end
	x = (b[14:0] > a[14:0]) ? b : a;   // Larger magnitude
	y = (b[14:0] > a[14:0]) ? a : b;
	ex = int'(x[14:10]);
	ey = int'(y[14:10]);
	mx = {5'b0, 1'b1, x[9:0], 16'h0000};   // Hidden bit at 26, 16 spare bits below
	myFull = {5'b0, 1'b1, y[9:0], 16'h0000};
	my = myFull >> (ex - ey);
	if ((my << (ex - ey)) != myFull) begin
		my = my | 32'd1;   // Lost bits
	end
	mr = (x[15] == y[15]) ? mx + my : mx - my;
	if (mr == 32'd0) begin
		return 16'h0000;   // Cancellation
	end
	lead = 31;
	while (!mr[lead]) begin
		lead--;
	end
	er = ex + lead - 26;
	sh = lead - 10;            // Keep eleven significant bits
	keep = mr >> sh;
	rem = mr - (keep << sh);
	halfWay = 32'd1 << (sh - 1);
	if (rem > halfWay || (rem == halfWay && keep[0])) begin
		keep++;
	end
	if (keep == 32'd2048) begin
		keep = 32'd1024;   // Rounding carried into a new binade
		er++;
	end
	if (er >= 31) begin
		return {x[15], 5'h1f, 10'h000};
	end
	if (er <= 0) begin
		return {x[15], 15'h0000};   // Flush, sign of the arithmetic
	end
	return {x[15], 5'(er), 10'(keep)};
endfunction

// Left to right from +0
function automatic half_t foldSum(input half_t vals [NumTerms]);
	half_t acc;
	acc = 16'h0000;
	for (int i = 0; i < NumTerms; i++) begin
		acc = fp16Add(acc, vals[i]);
	end
	return acc;
endfunction

// Normal value, random sign and fraction
function automatic half_t randHalf(input int eLo, input int eHi);
	logic [31:0] r;
	int e;
	r = nextRand();
	e = eLo + int'(r[23:16]) % (eHi - eLo + 1);
	return {r[31], 5'(e), r[9:0]};
endfunction

// Opposite sign, a few ulps away
function automatic half_t nearOpposite(input half_t x);
	logic [31:0] r;
	r = nextRand();
	return {~x[15], x[14:10], x[9:0] ^ {8'h00, r[1], 1'b1}};
endfunction

// Half an ulp of the base or one and a half, either sign
function automatic half_t halfUlpTerm(input half_t base);
	logic [31:0] r;
	r = nextRand();
	return {r[31], base[14:10] - 5'd11, r[30] ? 10'h200 : 10'h000};
endfunction

`endif

//--- verification/halfAccum_tb.sv
`timescale 1ns/1ps

module halfAccum_tb;
	import accum_pkg::*;

	localparam int ClkPeriod = 40;
	localparam int RandRuns = 10;
	localparam int NumRuns = RandRuns + 10;   // Directed and chained runs on top
	localparam int CyclesPerRun = 200;

	logic ap_clk;
	logic ap_rst;
	logic start;
	logic cont;
	logic done;
	logic idle;
	logic ready;
	logic accumValid;
	logic memCe;
	half_t accumSum;
	half_t memData;
	addr_t memAddr;

	half_t mem [NumTerms];      // Contents behind the read port
	addr_t readLog [$];         // Reads of the current run
	half_t lastExpected;
	logic [31:0] rngState = 32'h6817_0d61;
	int checkCount = 0;
	int errorCount = 0;

	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	`include "fp16Model.svh"

	halfAccum dut_i (
		.ap_clk(ap_clk),
		.ap_rst(ap_rst),
		.start(start),
		.cont(cont),
		.done(done),
		.idle(idle),
		.ready(ready),
		.accumValid(accumValid),
		.accumSum(accumSum),
		.memAddr(memAddr),
		.memCe(memCe),
		.memData(memData)
	);

	initial begin
		ap_clk = 1'b0;
		forever begin
			#(ClkPeriod / 2) ap_clk = ~ap_clk;
		end
	end

	always @(posedge ap_clk) begin
		if (memCe) begin
			memData <= mem[memAddr];   // One cycle read latency
		end
	end

	task automatic compare(input logic [15:0] got, input logic [15:0] expected,
			input string what);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
		end
	endtask

	// Strobe relations and read log, mid-cycle
	always @(negedge ap_clk) begin
		if (!ap_rst) begin
			compare(16'(ready), 16'(accumValid), "ready pulses with accumValid");
			if (accumValid) begin
				compare(16'(done), 16'd1, "done pulses with accumValid");
			end
			if (memCe) begin
				readLog.push_back(memAddr);
			end
		end
	end

	// Start already high when chained after cont
	task automatic runAccum(input string name, input logic chained);
		lastExpected = foldSum(mem);
		readLog.delete();
		if (!chained) begin
			@(posedge ap_clk);
			start <= 1'b1;
		end
		@(posedge ap_clk);
		start <= 1'b0;
		@(negedge ap_clk);
		while (!accumValid) begin
			compare(16'(idle), 16'd0, {name, ": idle while busy"});
			@(negedge ap_clk);
		end
		compare(accumSum, lastExpected, {name, ": sum"});
		compare(16'(readLog.size()), 16'(NumTerms), {name, ": read count"});
		foreach (readLog[i]) begin
			compare(16'(readLog[i]), 16'(i), {name, ": read order"});
		end
	endtask

	// Held done, ignored start, then cont
	task automatic releaseDone(input logic chainNext);
		@(posedge ap_clk);
		start <= 1'b1;
		@(negedge ap_clk);
		compare(16'(idle), 16'd0, "idle low with start high");
		@(posedge ap_clk);
		start <= 1'b0;
		repeat (3) begin
			@(negedge ap_clk);
			compare({13'h0, done, memCe, idle}, 16'h0005, "done held, no read, idle");
			compare(accumSum, lastExpected, "sum shown between runs");
		end
		@(posedge ap_clk);
		cont <= 1'b1;
		@(posedge ap_clk);
		cont <= 1'b0;
		start <= chainNext;
		@(negedge ap_clk);
		compare({14'h0, done, idle}, {15'h0, !chainNext}, "done cleared by cont");
	endtask

	task automatic singleRun(input string name);
		runAccum(name, 1'b0);
		releaseDone(1'b0);
	endtask

	initial begin
		ap_rst = 1'b1;
		start = 1'b0;
		cont = 1'b0;
		memData = 16'h0000;
		foreach (mem[i]) begin
			mem[i] = 16'h0000;
		end
		// Hand-worked answers for the model
		compare(fp16Add(16'h3C00, 16'h1000), 16'h3C00, "model tie, even kept");
		compare(fp16Add(16'h3C01, 16'h1000), 16'h3C02, "model tie, rounds up to even");
		compare(fp16Add(16'h3C00, 16'h1200), 16'h3C01, "model above tie");
		compare(fp16Add(16'h3C00, 16'hBC00), 16'h0000, "model cancellation");
		compare(fp16Add(16'h0400, 16'h8401), 16'h8000, "model flush");
		compare(fp16Add(16'h7800, 16'h7800), 16'h7C00, "model overflow");
		repeat (2) @(posedge ap_clk);
		ap_rst <= 1'b0;
		@(negedge ap_clk);
		compare({12'h0, done, ready, accumValid, memCe}, 16'h0000, "controls after reset");
		compare({15'h0, idle}, 16'h0001, "idle after reset");
		compare(accumSum, 16'h0000, "sum after reset");

		for (int r = 0; r < RandRuns; r++) begin
			foreach (mem[i]) begin
				mem[i] = randHalf(8, 22);
			end
			singleRun($sformatf("random %0d", r));
		end

		for (int i = 0; i < NumTerms; i += 2) begin
			mem[i] = randHalf(8, 22);
			mem[i+1] = mem[i] ^ 16'h8000;   // x then -x
		end
		singleRun("exact cancellation");
		for (int i = 0; i < NumTerms; i += 2) begin
			mem[i] = randHalf(8, 22);
			mem[i+1] = nearOpposite(mem[i]);
		end
		singleRun("near cancellation");
		mem = '{0: 16'h0400, 1: 16'h8401, default: 16'h8000};   // Tiny negative, flushed
		singleRun("flush");

		mem = '{16'h3C00, 16'h1000, 16'h1200, 16'h1000, 16'h0E00, 16'h9000, 16'h9200, 16'h1000};
		singleRun("directed rounding");
		mem[0] = randHalf(14, 16);
		mem[0][15] = 1'b0;
		for (int i = 1; i < NumTerms; i++) begin
			mem[i] = halfUlpTerm(mem[0]);
		end
		singleRun("random rounding");

		foreach (mem[i]) begin
			mem[i] = randHalf(30, 30);
			mem[i][15] = 1'b0;
		end
		singleRun("positive overflow");
		foreach (mem[i]) begin
			mem[i][15] = 1'b1;
		end
		singleRun("negative overflow");

		// Back to back, start in the cycle after cont
		foreach (mem[i]) begin
			mem[i] = randHalf(8, 22);
		end
		runAccum("chained 0", 1'b0);
		for (int k = 1; k < 3; k++) begin
			foreach (mem[i]) begin
				mem[i] = randHalf(8, 22);
			end
			releaseDone(1'b1);
			runAccum($sformatf("chained %0d", k), 1'b1);
		end
		releaseDone(1'b0);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(CyclesPerRun * NumRuns * ClkPeriod);
		$display("Timeout: runs did not finish within %0d cycles", CyclesPerRun * NumRuns);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- files.f
+incdir+verification
hdl/accum_pkg.sv
hdl/fpAddAlign.sv
hdl/fpAddExecute.sv
hdl/fpAddNormalize.sv
hdl/fpAddRound.sv
hdl/accumCtrl.sv
hdl/halfAccum.sv
verification/halfAccum_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= halfAccum_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG ?= === FAIL ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
